/* flist.f */
hw/tmu_pkg.sv
hw/tmu_if.sv
hw/tmu_ctlif.sv
hw/tmu_addresses.sv
hw/tmu_decay.sv
hw/tmu_burst.sv
hw/tmu_pixout.sv
hw/tmu.sv
bench/tmu_tb_mem.sv
bench/tmu_tb.sv

/* Makefile */
# Verilator build and run for the texture mapping unit testbench.

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tmu_tb -f flist.f -o tmu_tb

run: compile
	./obj_dir/tmu_tb | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/tmu_tb.sv */
/*
 * testbench for the texture mapping unit write back end.
 * runs fragment jobs into a memory model and checks the image and the CSRs.
 */

`timescale 1ns/100ps

module tmu_tb import tmu_pkg::*; ();

	localparam int NFRAG = 60;
	localparam int JOBS = 4;
	localparam int MEM_BYTES = 4096;
	localparam int unsigned FB_BASE = 32'h420; // frame buffer start, line aligned.
	localparam int unsigned HRES = 64;

	logic sys_clk;
	logic sys_rst;
	logic frag_stb;
	logic frag_ack;
	logic [COORD_W-1:0] frag_x;
	logic [COORD_W-1:0] frag_y;
	pixel_t frag_pixel;
	logic frag_last;
	logic [13:0] csr_a;
	logic csr_we;
	logic [31:0] csr_di;
	logic [31:0] csr_do;
	logic irq;
	logic [FML_DEPTH-1:0] fmlw_adr;
	logic fmlw_stb;
	logic fmlw_ack;
	logic [7:0] fmlw_sel;
	logic [63:0] fmlw_do;
	logic preset;
	logic rand_ack;

	integer seed;
	int errors;
	int errors_before;
	int tests_run;
	int tests_failed;
	int irq_count;
	logic [31:0] d;
	logic [COORD_W-1:0] fx [];
	logic [COORD_W-1:0] fy [];
	pixel_t fp [];
	logic [7:0] expect_mem [];

	tmu dut (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.frag_stb_i(frag_stb), .frag_ack_o(frag_ack), .frag_x_i(frag_x), .frag_y_i(frag_y),
		.frag_pixel_i(frag_pixel), .frag_last_i(frag_last),
		.csr_a_i(csr_a), .csr_we_i(csr_we), .csr_di_i(csr_di), .csr_do_o(csr_do),
		.irq_o(irq),
		.fmlw_adr_o(fmlw_adr), .fmlw_stb_o(fmlw_stb), .fmlw_ack_i(fmlw_ack),
		.fmlw_sel_o(fmlw_sel), .fmlw_do_o(fmlw_do)
	);

	tmu_tb_mem mem (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .preset_i(preset), .rand_ack_i(rand_ack),
		.fmlw_adr_i(fmlw_adr), .fmlw_stb_i(fmlw_stb), .fmlw_ack_o(fmlw_ack),
		.fmlw_sel_i(fmlw_sel), .fmlw_do_i(fmlw_do)
	);

	initial sys_clk = 1'b0;
	always #5 sys_clk = ~sys_clk;

	function automatic logic [7:0] fill_byte(input int a);
		return 8'(a ^ (a >> 8) ^ 'h5a);
	endfunction

	// expected destination address and decayed pixel of one fragment.
	function automatic logic [FML_DEPTH+15:0] expect_frag(input int unsigned x,
			input int unsigned y, input pixel_t p, input int unsigned bright);
		int unsigned adr;
		pixel_t q;
		adr = FB_BASE + 2 * (y * HRES + x);
		q.r = 5'((32'(p.r) * (bright + 1)) >> 6);
		q.g = 6'((32'(p.g) * (bright + 1)) >> 6);
		q.b = 5'((32'(p.b) * (bright + 1)) >> 6);
		return {adr[FML_DEPTH-1:0], q};
	endfunction

	function automatic logic [13:0] csr_addr(input csr_reg_e r);
		return {CSR_ADDR, 7'd0, r};
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] want);
		assert (got == want) else begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
			errors++;
		end
	endtask

	// all driving tasks start and end on a falling edge.
	task automatic csr_write(input csr_reg_e r, input logic [31:0] value);
		csr_a = csr_addr(r);
		csr_di = value;
		csr_we = 1'b1;
		@(negedge sys_clk);
		csr_we = 1'b0;
	endtask

	task automatic csr_read(input logic [13:0] a, output logic [31:0] value);
		csr_a = a;
		csr_we = 1'b0;
		@(negedge sys_clk);
		value = csr_do; // registered one cycle after the address.
	endtask

	task automatic make_frags();
		logic [31:0] rnd;
		for (int i = 0; i < NFRAG; i++) begin
			rnd = $random(seed);
			fx[i] = COORD_W'(rnd[15:0] % 40);
			fy[i] = COORD_W'(rnd[31:16] % 6);
			rnd = $random(seed);
			fp[i] = rnd[15:0];
		end
	endtask

	task automatic build_expect(input int bright);
		logic [FML_DEPTH+15:0] ref_val;
		int unsigned a;
		for (int i = 0; i < MEM_BYTES; i++)
			expect_mem[i] = fill_byte(i);
		// later fragments win at the same address.
		for (int i = 0; i < NFRAG; i++) begin
			ref_val = expect_frag(32'(fx[i]), 32'(fy[i]), fp[i], bright);
			a = 32'(ref_val[FML_DEPTH+15:16]);
			expect_mem[a] = ref_val[15:8]; // high byte at the even address.
			expect_mem[a + 1] = ref_val[7:0];
		end
	endtask

	task automatic send_frag(input int i, input logic last);
		frag_stb = 1'b1;
		frag_x = fx[i];
		frag_y = fy[i];
		frag_pixel = fp[i];
		frag_last = last;
		// ack comes from registered state only, so it is settled at the falling edge.
		while (!frag_ack)
			@(negedge sys_clk);
		@(negedge sys_clk);
		frag_stb = 1'b0;
		frag_last = 1'b0;
	endtask

	task automatic run_job(input int bright, input logic gaps, input int restart_at);
		int irq_before;
		logic [31:0] rnd;
		logic [31:0] value;
		build_expect(bright);
		csr_write(CSR_BRIGHT, bright);
		csr_write(CSR_FBUF, FB_BASE);
		csr_write(CSR_HRES, HRES);
		preset = 1'b1;
		@(negedge sys_clk);
		preset = 1'b0;
		irq_before = irq_count;
		csr_write(CSR_CTL, 32'd1);
		for (int i = 0; i < NFRAG; i++) begin
			if (i == restart_at)
				csr_write(CSR_CTL, 32'd1); // the job is busy, so this start is ignored.
			send_frag(i, i == NFRAG - 1);
			if (gaps) begin
				rnd = $random(seed);
				repeat (rnd[1:0]) @(negedge sys_clk);
			end
		end
		wait (irq_count != irq_before);
		repeat (50) @(negedge sys_clk); // room for a second pulse to show up.
		check_value("irq pulses", 32'(irq_count - irq_before), 32'd1);
		csr_read(csr_addr(CSR_CTL), value);
		check_value("busy bit", value, 32'd0);
		csr_read(csr_addr(CSR_PIXELS), value);
		check_value("pixel count", value, NFRAG);
	endtask

	task automatic finish_test(input string name);
		if (errors == errors_before) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d errors", name, errors - errors_before);
			tests_failed++;
		end
		tests_run++;
		errors_before = errors;
	endtask

	// the image is complete once irq is seen, so compare every byte then.
	always @(negedge sys_clk) begin
		if (irq) begin
			irq_count = irq_count + 1;
			for (int a = 0; a < MEM_BYTES; a++)
				assert (mem.cells[12'(a)] == expect_mem[a]) else begin
					$display("error at %0t ns: byte %h holds %h, expected %h",
						$time, a, mem.cells[12'(a)], expect_mem[a]);
					errors++;
				end
		end
	end

	initial begin
		#((200 * JOBS * NFRAG + 2000) * 10);
		$display("watchdog expired before all tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		seed = 50;
		errors = 0;
		errors_before = 0;
		tests_run = 0;
		tests_failed = 0;
		irq_count = 0;
		fx = new[NFRAG];
		fy = new[NFRAG];
		fp = new[NFRAG];
		expect_mem = new[MEM_BYTES];
		frag_stb = 1'b0;
		frag_x = '0;
		frag_y = '0;
		frag_pixel = '0;
		frag_last = 1'b0;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		preset = 1'b0;
		rand_ack = 1'b0;
		sys_rst = 1'b1;
		repeat (5) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;

		csr_write(CSR_BRIGHT, 32'd42);
		csr_write(CSR_FBUF, 32'h0234_5678);
		csr_write(CSR_HRES, 32'd1234);
		csr_read(csr_addr(CSR_BRIGHT), d);
		check_value("brightness", d, 32'd42);
		csr_read(csr_addr(CSR_FBUF), d);
		check_value("frame buffer", d, 32'h0234_5678);
		csr_read(csr_addr(CSR_HRES), d);
		check_value("hres", d, 32'd1234);
		csr_read(14'h0c01, d);
		check_value("foreign register", d, 32'd0);
		finish_test("csr access");

		make_frags();
		run_job(63, 1'b0, -1);
		finish_test("full brightness job");

		rand_ack = 1'b1; // same fragments, now with stalls on both sides.
		run_job(63, 1'b1, -1);
		rand_ack = 1'b0;
		finish_test("back-pressure");

		make_frags();
		run_job(20, 1'b0, -1);
		finish_test("decay");

		make_frags();
		run_job(63, 1'b0, NFRAG / 2);
		finish_test("job end");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* bench/tmu_tb_mem.sv */
/*
 * frame buffer memory model.
 * bytes behind the write port, acknowledged after an optional random delay.
 */

`timescale 1ns/100ps

module tmu_tb_mem import tmu_pkg::*; (
	input  logic                 sys_clk,
	input  logic                 sys_rst,
	input  logic                 preset_i,
	input  logic                 rand_ack_i,
	input  logic [FML_DEPTH-1:0] fmlw_adr_i,
	input  logic                 fmlw_stb_i,
	output logic                 fmlw_ack_o,
	input  logic [7:0]           fmlw_sel_i,
	input  logic [63:0]          fmlw_do_i
);

	logic [7:0] cells [4096];
	logic [11:0] base;
	logic [2:0] beats_left;
	logic [1:0] delay;
	logic waiting;
	logic [31:0] rnd;
	integer seed;

	initial seed = 50;

	always @(posedge sys_clk) begin
		// every byte gets a value that depends on its whole address.
		if (preset_i)
			for (int a = 0; a < 4096; a++)
				cells[12'(a)] <= 8'(a ^ (a >> 8) ^ 'h5a);
		if (sys_rst) begin
			fmlw_ack_o <= 1'b0;
			beats_left <= 3'd0;
			waiting <= 1'b0;
			delay <= 2'd0;
		end else begin
			fmlw_ack_o <= 1'b0;
			if (fmlw_ack_o && fmlw_stb_i) begin
				base <= fmlw_adr_i[11:0]; // the four beats start on the next cycle.
				beats_left <= 3'd4;
			end else if (beats_left != 3'd0) begin
				for (int i = 0; i < 8; i++)
					if (fmlw_sel_i[7 - i])
						cells[base + 12'(i)] <= fmlw_do_i[63 - 8*i -: 8];
				base <= base + 12'd8;
				beats_left <= beats_left - 3'd1;
			end else if (fmlw_stb_i) begin
				if (!waiting) begin
					rnd = $random(seed);
					delay <= rand_ack_i ? rnd[1:0] : 2'd0; // 0 to 3 extra cycles.
					waiting <= 1'b1;
				end else if (delay != 2'd0) begin
					delay <= delay - 2'd1;
				end else begin
					waiting <= 1'b0;
					fmlw_ack_o <= 1'b1;
				end
			end
		end
	end

endmodule

/* hw/tmu.sv */
/*
 * texture mapping unit, write back end.
 * address, decay, burst and output stages under the control interface.
 */

`timescale 1ns/100ps

module tmu import tmu_pkg::*; (
	input  logic                 sys_clk,
	input  logic                 sys_rst,

	input  logic                 frag_stb_i,
	output logic                 frag_ack_o,
	input  logic [COORD_W-1:0]   frag_x_i,
	input  logic [COORD_W-1:0]   frag_y_i,
	input  pixel_t               frag_pixel_i,
	input  logic                 frag_last_i,

	input  logic [13:0]          csr_a_i,
	input  logic                 csr_we_i,
	input  logic [31:0]          csr_di_i,
	output logic [31:0]          csr_do_o,

	output logic                 irq_o,

	output logic [FML_DEPTH-1:0] fmlw_adr_o,
	output logic                 fmlw_stb_o,
	input  logic                 fmlw_ack_i,
	output logic [7:0]           fmlw_sel_o,
	output logic [63:0]          fmlw_do_o
);

	logic [5:0] brightness;
	logic [FML_DEPTH-1:0] fbuf;
	logic [COORD_W-1:0] hres;
	logic flush;
	logic frag_accept;
	logic frag_last;
	logic addr_busy;
	logic decay_busy;
	logic burst_busy;
	logic pixout_busy;

	pix_link addr_pix ();
	pix_link decay_pix ();
	burst_link line_bl ();

	tmu_ctlif ctlif (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.csr_a_i(csr_a_i), .csr_we_i(csr_we_i), .csr_di_i(csr_di_i), .csr_do_o(csr_do_o),
		.irq_o(irq_o),
		.addr_busy_i(addr_busy), .decay_busy_i(decay_busy),
		.burst_busy_i(burst_busy), .pixout_busy_i(pixout_busy),
		.frag_accept_i(frag_accept), .frag_last_i(frag_last),
		.brightness_o(brightness), .fbuf_o(fbuf), .hres_o(hres), .flush_o(flush)
	);

	tmu_addresses addresses (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.frag_stb_i(frag_stb_i), .frag_ack_o(frag_ack_o),
		.frag_x_i(frag_x_i), .frag_y_i(frag_y_i),
		.frag_pixel_i(frag_pixel_i), .frag_last_i(frag_last_i),
		.fbuf_i(fbuf), .hres_i(hres),
		.accept_o(frag_accept), .last_o(frag_last), .busy_o(addr_busy),
		.pix_o(addr_pix)
	);

	tmu_decay decay (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.brightness_i(brightness),
		.pix_i(addr_pix), .pix_o(decay_pix),
		.busy_o(decay_busy)
	);

	tmu_burst burst (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.flush_i(flush),
		.pix_i(decay_pix), .burst_o(line_bl),
		.busy_o(burst_busy)
	);

	tmu_pixout pixout (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.burst_i(line_bl),
		.fmlw_adr_o(fmlw_adr_o), .fmlw_stb_o(fmlw_stb_o), .fmlw_ack_i(fmlw_ack_i),
		.fmlw_sel_o(fmlw_sel_o), .fmlw_do_o(fmlw_do_o),
		.busy_o(pixout_busy)
	);

endmodule

/* hw/tmu_pixout.sv */
/*
 * pixel output.
 * writes one line to memory as an address phase and four 64-bit beats.
 */

`timescale 1ns/100ps

module tmu_pixout import tmu_pkg::*; (
	input  logic                 sys_clk,
	input  logic                 sys_rst,

	burst_link.sink              burst_i,

	output logic [FML_DEPTH-1:0] fmlw_adr_o,
	output logic                 fmlw_stb_o,
	input  logic                 fmlw_ack_i,
	output logic [7:0]           fmlw_sel_o,
	output logic [63:0]          fmlw_do_o,

	output logic                 busy_o
);

	typedef enum logic [1:0] {
		PO_WAIT,
		PO_ADDR,
		PO_DATA
	} pixout_state_e;

	pixout_state_e state;
	logic [1:0] beat;
	logic last_beat;
	logic [3:0] beat_sel;

	assign last_beat = (beat == 2'(BEATS-1));

	// the line stays on the link until the last beat, so nothing is copied.
	assign burst_i.ack = (state == PO_DATA) & last_beat;
	assign busy_o = (state != PO_WAIT);

	assign fmlw_stb_o = (state == PO_ADDR);
	assign fmlw_adr_o = {burst_i.adr, 5'd0};
	assign fmlw_do_o = burst_i.data[BURST_PIXELS*16-1 - 64*beat -: 64];

	// one enable per pixel becomes two byte enables.
	assign beat_sel = burst_i.sel[BURST_PIXELS-1 - 4*beat -: 4];
	assign fmlw_sel_o = (state == PO_DATA) ?
		{{2{beat_sel[3]}}, {2{beat_sel[2]}}, {2{beat_sel[1]}}, {2{beat_sel[0]}}} : 8'd0;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= PO_WAIT;
			beat <= 2'd0;
		end else begin
			case (state)
				PO_WAIT: if (burst_i.stb) state <= PO_ADDR;
				PO_ADDR: begin
					beat <= 2'd0;
					if (fmlw_ack_i)
						state <= PO_DATA; // data follows on the next cycle.
				end
				PO_DATA: begin
					beat <= beat + 2'd1;
					if (last_beat)
						state <= PO_WAIT;
				end
				default: state <= PO_WAIT;
			endcase
		end
	end

	a_adr_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fmlw_stb_o && !fmlw_ack_i |=> fmlw_stb_o && $stable(fmlw_adr_o));

endmodule

/* hw/tmu_burst.sv */
/*
 * burst assembler.
 * gathers pixels of one 32-byte line with per-pixel enables and hands the
 * line on when a pixel of another line arrives or on flush.
 */

`timescale 1ns/100ps

module tmu_burst import tmu_pkg::*; (
	input  logic     sys_clk,
	input  logic     sys_rst,

	input  logic     flush_i,

	pix_link.sink    pix_i,
	burst_link.source burst_o,

	output logic     busy_o
);

	burst_adr_t line_adr;
	logic [BURST_PIXELS*16-1:0] line_data;
	logic [BURST_PIXELS-1:0] line_sel;

	burst_adr_t in_line;
	logic [3:0] in_idx; // pixel index within the line.
	logic [BURST_PIXELS-1:0] pix_bit;
	logic same_line;
	logic out_free;
	logic take;
	logic emit;

	assign in_line = pix_i.adr[FML_DEPTH-1:5];
	assign in_idx = pix_i.adr[4:1];
	assign pix_bit = {1'b1, {(BURST_PIXELS-1){1'b0}}} >> in_idx;

	// an empty line takes any pixel.
	assign same_line = (line_sel == '0) | (in_line == line_adr);
	assign out_free = ~burst_o.stb | burst_o.ack;

	assign pix_i.ack = ~flush_i & (same_line | out_free);
	assign take = pix_i.stb & pix_i.ack;
	assign emit = (line_sel != '0) & out_free & (flush_i | (take & ~same_line));

	assign busy_o = burst_o.stb;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			burst_o.stb <= 1'b0;
			line_sel <= '0;
		end else begin
			if (emit)
				burst_o.stb <= 1'b1;
			else if (burst_o.ack)
				burst_o.stb <= 1'b0;

			if (flush_i && out_free)
				line_sel <= '0;
			else if (take && same_line)
				line_sel <= line_sel | pix_bit;
			else if (take)
				line_sel <= pix_bit; // new line starts with this pixel alone.
		end
	end

	always_ff @(posedge sys_clk) begin
		if (emit) begin
			burst_o.adr <= line_adr;
			burst_o.sel <= line_sel;
			burst_o.data <= line_data;
		end
		// a later pixel at the same index simply overwrites the slot.
		if (take) begin
			line_adr <= in_line;
			line_data[BURST_PIXELS*16-1 - 16*in_idx -: 16] <= pix_i.pixel;
		end
	end

	a_sel_nonzero: assert property (@(posedge sys_clk) disable iff (sys_rst)
		burst_o.stb && burst_o.ack |-> burst_o.sel != '0);

endmodule

/* hw/tmu_decay.sv */
/*
 * brightness decay.
 * scales each colour channel by (brightness + 1) / 64 over two stages.
 */

`timescale 1ns/100ps

module tmu_decay import tmu_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst,

	input  logic [5:0] brightness_i,

	pix_link.sink      pix_i,
	pix_link.source    pix_o,

	output logic       busy_o
);

	logic [6:0] gain;
	logic s1_stb;
	logic [10:0] s1_r;
	logic [11:0] s1_g;
	logic [10:0] s1_b;
	logic [FML_DEPTH-1:0] s1_adr;
	logic s1_free;
	logic s2_free;

	assign gain = {1'b0, brightness_i} + 7'd1; // 63 gives 64, a unity gain.

	assign s2_free = ~pix_o.stb | pix_o.ack;
	assign s1_free = ~s1_stb | s2_free;
	assign pix_i.ack = s1_free;
	assign busy_o = s1_stb | pix_o.stb;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			s1_stb <= 1'b0;
			pix_o.stb <= 1'b0;
		end else begin
			if (s1_free)
				s1_stb <= pix_i.stb;
			if (s2_free)
				pix_o.stb <= s1_stb;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (s1_free && pix_i.stb) begin
			s1_r <= pix_i.pixel.r * gain;
			s1_g <= pix_i.pixel.g * gain;
			s1_b <= pix_i.pixel.b * gain;
			s1_adr <= pix_i.adr;
		end
		if (s2_free && s1_stb) begin
			pix_o.pixel.r <= s1_r[10:6]; // drop the six fraction bits.
			pix_o.pixel.g <= s1_g[11:6];
			pix_o.pixel.b <= s1_b[10:6];
			pix_o.adr <= s1_adr;
		end
	end

endmodule

/* hw/tmu_addresses.sv */
/*
 * destination address stage.
 * turns fragment coordinates into a frame buffer byte address in one cycle.
 */

`timescale 1ns/100ps

module tmu_addresses import tmu_pkg::*; (
	input  logic                 sys_clk,
	input  logic                 sys_rst,

	input  logic                 frag_stb_i,
	output logic                 frag_ack_o,
	input  logic [COORD_W-1:0]   frag_x_i,
	input  logic [COORD_W-1:0]   frag_y_i,
	input  pixel_t               frag_pixel_i,
	input  logic                 frag_last_i,

	input  logic [FML_DEPTH-1:0] fbuf_i,
	input  logic [COORD_W-1:0]   hres_i,

	output logic                 accept_o,
	output logic                 last_o,
	output logic                 busy_o,

	pix_link.source              pix_o
);

	logic [2*COORD_W:0] offset; // pixel index within the frame.

	assign offset = frag_y_i * hres_i + frag_x_i;

	assign frag_ack_o = ~pix_o.stb | pix_o.ack;
	assign accept_o = frag_stb_i & frag_ack_o;
	assign last_o = accept_o & frag_last_i;
	assign busy_o = pix_o.stb;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pix_o.stb <= 1'b0;
		else if (frag_ack_o)
			pix_o.stb <= frag_stb_i;
	end

	always_ff @(posedge sys_clk) begin
		if (accept_o) begin
			pix_o.adr <= fbuf_i + FML_DEPTH'({offset, 1'b0}); // two bytes per pixel.
			pix_o.pixel <= frag_pixel_i;
		end
	end

endmodule

/* hw/tmu_ctlif.sv */
/*
 * control interface of the texture mapping unit.
 * holds the configuration registers, sequences a job through the end-of-job
 * flush, raises the interrupt and counts the accepted fragments.
 */

`timescale 1ns/100ps

module tmu_ctlif import tmu_pkg::*; (
	input  logic                 sys_clk,
	input  logic                 sys_rst,

	input  logic [13:0]          csr_a_i,
	input  logic                 csr_we_i,
	input  logic [31:0]          csr_di_i,
	output logic [31:0]          csr_do_o,

	output logic                 irq_o,

	input  logic                 addr_busy_i,
	input  logic                 decay_busy_i,
	input  logic                 burst_busy_i,
	input  logic                 pixout_busy_i,
	input  logic                 frag_accept_i,
	input  logic                 frag_last_i,

	output logic [5:0]           brightness_o,
	output logic [FML_DEPTH-1:0] fbuf_o,
	output logic [COORD_W-1:0]   hres_o,
	output logic                 flush_o
);

	ctl_state_e state;
	csr_reg_e csr_reg;
	logic csr_sel;
	logic start;
	logic pipe_busy;
	logic [31:0] pixels;

	assign csr_sel = (csr_a_i[13:10] == CSR_ADDR);
	assign csr_reg = csr_reg_e'(csr_a_i[2:0]);
	assign start = csr_sel & csr_we_i & (csr_reg == CSR_CTL) & csr_di_i[0];
	assign pipe_busy = addr_busy_i | decay_busy_i | burst_busy_i | pixout_busy_i;
	assign flush_o = (state == FLUSH);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			brightness_o <= 6'd63;
			fbuf_o <= '0;
			hres_o <= '0;
			csr_do_o <= 32'd0;
		end else begin
			csr_do_o <= 32'd0; // foreign addresses read as zero.
			if (csr_sel) begin
				if (csr_we_i) begin
					case (csr_reg)
						CSR_BRIGHT: brightness_o <= csr_di_i[5:0];
						CSR_FBUF:   fbuf_o <= csr_di_i[FML_DEPTH-1:0];
						CSR_HRES:   hres_o <= csr_di_i[COORD_W-1:0];
						default:    ;
					endcase
				end
				case (csr_reg)
					CSR_CTL:    csr_do_o <= {31'd0, state != IDLE};
					CSR_BRIGHT: csr_do_o <= 32'(brightness_o);
					CSR_FBUF:   csr_do_o <= 32'(fbuf_o);
					CSR_HRES:   csr_do_o <= 32'(hres_o);
					CSR_PIXELS: csr_do_o <= pixels;
					default:    csr_do_o <= 32'd0;
				endcase
			end
		end
	end

	// job sequencer. the stages report busy while they hold an item.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= IDLE;
			irq_o <= 1'b0;
		end else begin
			irq_o <= 1'b0;
			case (state)
				IDLE:         if (start) state <= RUN;
				RUN:          if (frag_last_i) state <= WAIT_PROCESS;
				WAIT_PROCESS: if (!pipe_busy) state <= FLUSH;
				FLUSH:        state <= WAIT_FLUSH; // the partial line is pushed out here.
				WAIT_FLUSH: begin
					if (!pipe_busy) begin
						state <= IDLE;
						irq_o <= 1'b1;
					end
				end
				default:      state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pixels <= 32'd0;
		else if (start && state == IDLE)
			pixels <= 32'd0;
		else if (frag_accept_i)
			pixels <= pixels + 32'd1;
	end

	// flush only reaches a pipeline in which every stage has drained.
	a_flush_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
		flush_o |-> !pipe_busy);

	a_irq_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
		irq_o |=> !irq_o);

endmodule

/* hw/tmu_if.sv */
/*
 * pipeline links between the stages.
 * the source holds stb and payload until it sees ack in the same cycle.
 */

`timescale 1ns/100ps

interface pix_link import tmu_pkg::*; ();

	logic stb;
	logic ack;
	pixel_t pixel;
	logic [FML_DEPTH-1:0] adr; // destination byte address.

	modport source (output stb, output pixel, output adr, input ack);
	modport sink (input stb, input pixel, input adr, output ack);

endinterface

interface burst_link import tmu_pkg::*; ();

	logic stb;
	logic ack;
	burst_adr_t adr;
	logic [BURST_PIXELS-1:0] sel; // bit 15 is the pixel at the lowest address.
	logic [BURST_PIXELS*16-1:0] data; // lowest address in the top bits.

	modport source (output stb, output adr, output sel, output data, input ack);
	modport sink (input stb, input adr, input sel, input data, output ack);

endinterface

/* hw/tmu_pkg.sv */
/*
 * texture mapping unit, write back end.
 * sizes, register map, control states and pixel format shared by all blocks.
 */

package tmu_pkg;

	localparam int FML_DEPTH = 26; // memory byte address width.
	localparam int COORD_W = 11; // x, y and horizontal resolution.

	localparam logic [3:0] CSR_ADDR = 4'h2; // matched against csr_a[13:10].

	// register numbers, decoded from the low bits of the CSR address.
	typedef enum logic [2:0] {
		CSR_CTL    = 3'd0, // write bit 0 to start, read bit 0 for busy.
		CSR_BRIGHT = 3'd1,
		CSR_FBUF   = 3'd2,
		CSR_HRES   = 3'd3,
		CSR_PIXELS = 3'd4
	} csr_reg_e;

	// job sequencing.
	typedef enum logic [2:0] {
		IDLE,
		RUN,
		WAIT_PROCESS,
		FLUSH,
		WAIT_FLUSH
	} ctl_state_e;

	// RGB565, red in the top bits.
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} pixel_t;

	localparam int BURST_PIXELS = 16; // one 32-byte line.
	localparam int BEATS = 4; // 64-bit beats per line.

	// a line address is the byte address without its low 5 bits.
	typedef logic [FML_DEPTH-6:0] burst_adr_t;

endpackage
